/* build.f */
hw/idecPkg.sv
hw/idecCfgRegs.sv
hw/idecUnitClass.sv
hw/idecMemExcClass.sv
hw/idecConstExtract.sv
hw/idecOutStage.sv
hw/idecTop.sv
verif/idecClkGen.sv
verif/idecTb.sv

/* hw/idecCfgRegs.sv */
// Mode bits change only on a write strobe; a new value steers the decode from the next edge on
`timescale 1ns/1ps
`default_nettype none

module idecCfgRegs import idecPkg::*; (
    input  wire logic clk,
    input  wire logic rst_i,
    input  wire logic cfgWe_i,
    input  wire cfg_t cfgData_i,
    output cfg_t      cfg_o
);

    // Debug mode and predication bits
    cfg_t cfgQ;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cfgQ <= '0;
        end else if (cfgWe_i) begin
            cfgQ <= cfgData_i;
        end
    end

    assign cfg_o = cfgQ;

endmodule

`default_nettype wire

/* hw/idecConstExtract.sv */
// Combinational; constVal is formed for every instruction and only meaningful when hasConst is set
`timescale 1ns/1ps
`default_nettype none

module idecConstExtract import idecPkg::*; (
    input  wire logic [InstrW-1:0] instr_i,
    input  wire logic              predOn_i,
    output constInfo_t             cinfo_o
);

    opcode_e     op;
    logic        isStore;
    logic [29:0] longImm;
    logic [13:0] shortImm;

    assign op      = opcode_e'(instr_i[OpHi:OpLo]);
    assign isStore = isStoreOp(op);

    // Stores have the data register in 22:18 so the constant is split around it
    assign longImm  = isStore ? {instr_i[47:23], instr_i[17:13]} : instr_i[47:18];
    assign shortImm = isStore ? {instr_i[31:23], instr_i[17:13]} : instr_i[31:18];

    always_comb begin
        cinfo_o = '0;
        case (op)
            OpAddi, OpAndi, OpOri, OpMuli, OpDivi: cinfo_o.hasConst = 1'b1;
            OpJal, OpCall, OpRet:                  cinfo_o.hasConst = 1'b1;
            default: cinfo_o.hasConst = isLoadOp(op) || isStore;
        endcase

        // Long form uses the upper parcel
        if (instr_i[LongBit]) begin
            cinfo_o.constVal = {{(ConstW-30){longImm[29]}}, longImm};
        end else begin
            cinfo_o.constVal = {{(ConstW-14){shortImm[13]}}, shortImm};
        end

        // Length in parcels, low bit flags the predicate prefix
        case (instr_i[7:6])
            2'b00:   cinfo_o.len = 3'd4 | {2'b00, predOn_i};
            2'b01:   cinfo_o.len = 3'd6 | {2'b00, predOn_i};
            default: cinfo_o.len = 3'd2 | {2'b00, predOn_i};
        endcase
    end

endmodule

`default_nettype wire

/* hw/idecMemExcClass.sv */
// Combinational; in debug mode every instruction is marked as able to raise an exception
`timescale 1ns/1ps
`default_nettype none

module idecMemExcClass import idecPkg::*; (
    input  wire logic [InstrW-1:0] instr_i,
    input  wire logic [RegW-1:0]   rt_i,
    input  wire logic              debugOn_i,
    output memFlags_t              memf_o
);

    opcode_e     op;
    funct_e      fn;
    logic        isLoad;
    logic        isStore;
    logic        isMem;
    logic [10:0] brDisp;
    logic        selfLoop;

    assign op      = opcode_e'(instr_i[OpHi:OpLo]);
    assign fn      = funct_e'(instr_i[FnHi:FnLo]);
    assign isLoad  = isLoadOp(op);
    assign isStore = isStoreOp(op);
    // RET pops its return address from memory
    assign isMem   = isLoad || isStore || (op == OpRet);
    assign brDisp  = instr_i[DispHi:DispLo];

    // Branch only faults when it targets itself
    assign selfLoop = instr_i[DirBit] ? (brDisp == LoopDispBack) : (brDisp == LoopDispFwd);

    // Size field shared by the LX and SX forms
    function automatic memSize_e sizeFromField(logic [3:0] szField);
        memSize_e sz;
        if (szField == 4'b1000) begin
            sz = SzHexi;
        end else if (szField[2]) begin
            sz = SzOcta;
        end else if (szField[1]) begin
            sz = SzTetra;
        end else if (szField[0]) begin
            sz = SzWyde;
        end else begin
            sz = SzOcta;
        end
        return sz;
    endfunction

    // ====================
    // Memory class
    // ====================
    always_comb begin
        memf_o         = '0;
        memf_o.load    = isLoad;
        memf_o.store   = isStore;
        memf_o.mem     = isMem;
        memf_o.preload = isLoad && (rt_i == '0);
        case (op)
            OpLb, OpLbu, OpSb: memf_o.memSize = SzByte;
            OpLx:              memf_o.memSize = sizeFromField(instr_i[LxSzHi:LxSzLo]);
            OpSx:              memf_o.memSize = sizeFromField(instr_i[SxSzHi:SxSzLo]);
            default:           memf_o.memSize = SzOcta;
        endcase

        // Exception capability
        if (debugOn_i) begin
            memf_o.canExc = 1'b1;
        end else begin
            case (op)
                OpFloat, OpMuli, OpDivi: memf_o.canExc = 1'b1;
                OpR2: begin
                    memf_o.canExc = (fn == FnMul) || (fn == FnDiv) || (fn == FnRti);
                end
                OpBcc:   memf_o.canExc = selfLoop;
                default: memf_o.canExc = isMem;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/idecOutStage.sv */
// Captures on every edge with no stall; the consumer must take each word while idv_o is high
`timescale 1ns/1ps
`default_nettype none

module idecOutStage import idecPkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_i,
    input  wire unitFlags_t      unit_i,
    input  wire memFlags_t       memf_i,
    input  wire constInfo_t      cinfo_i,
    input  wire logic [TagW-1:0] id_i,
    input  wire logic            idv_i,
    output decodeBus_t           bus_o,
    output logic [TagW-1:0]      id_o,
    output logic                 idv_o
);

    decodeBus_t busD;

    // Assemble the decode word
    always_comb begin
        busD       = '0;
        busD.unit  = unit_i;
        busD.memf  = memf_i;
        busD.cinfo = cinfo_i;
    end

    // ====================
    // Output register
    // ====================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus_o <= '0;
            id_o  <= '0;
            idv_o <= 1'b0;
        end else begin
            bus_o <= busD;
            id_o  <= id_i;
            idv_o <= idv_i;
        end
    end

endmodule

`default_nettype wire

/* hw/idecPkg.sv */
// Reduced private opcode map for the 48-bit core, not the full production encoding
`default_nettype none

package idecPkg;

    // ====================
    // Widths
    // ====================
    localparam int InstrW = 48;
    localparam int TagW   = 5;
    localparam int RegW   = 5;
    localparam int ConstW = 64;

    // Instruction field positions
    localparam int OpHi    = 5;
    localparam int OpLo    = 0;
    localparam int FnHi    = 31;
    localparam int FnLo    = 26;
    localparam int DispHi  = 31;
    localparam int DispLo  = 21;
    localparam int LxSzHi  = 21;
    localparam int LxSzLo  = 18;
    localparam int SxSzHi  = 16;
    localparam int SxSzLo  = 13;
    localparam int LongBit = 6;
    localparam int DirBit  = 7;

    // Branch to self, forward and backward forms
    localparam logic [10:0] LoopDispFwd  = 11'h7FE;
    localparam logic [10:0] LoopDispBack = 11'h7FF;

    // ====================
    // Encodings
    // ====================
    typedef enum logic [5:0] {
        OpBrk   = 6'd0,
        OpR2    = 6'd2,
        OpAddi  = 6'd4,
        OpCmpi  = 6'd6,
        OpAndi  = 6'd8,
        OpOri   = 6'd9,
        OpMuli  = 6'd12,
        OpDivi  = 6'd13,
        OpFloat = 6'd15,
        OpJal   = 6'd24,
        OpCall  = 6'd25,
        OpLb    = 6'd32,
        OpLbu   = 6'd33,
        OpLx    = 6'd34,
        OpJmp   = 6'd40,
        OpRet   = 6'd41,
        OpBcc   = 6'd48,
        OpSb    = 6'd56,
        OpSx    = 6'd57
    } opcode_e;

    typedef enum logic [5:0] {
        FnAdd = 6'd4,
        FnSub = 6'd5,
        FnCmp = 6'd6,
        FnAnd = 6'd8,
        FnOr  = 6'd9,
        FnMin = 6'd44,
        FnMax = 6'd45,
        FnRti = 6'd55,
        FnMul = 6'd58,
        FnDiv = 6'd62
    } funct_e;

    typedef enum logic [2:0] {
        SzByte  = 3'd0,
        SzWyde  = 3'd1,
        SzTetra = 3'd2,
        SzOcta  = 3'd3,
        SzHexi  = 3'd4
    } memSize_e;

    // ====================
    // Decode bus
    // ====================
    typedef struct packed {
        logic debugOn;
        logic predOn;
    } cfg_t;

    typedef struct packed {
        logic alu;
        logic alu0Only;
        logic fpu;
        logic flowCtrl;
        logic branch;
        logic jmp;
        logic updateBtb;
        logic rfw;
        logic prfw;
    } unitFlags_t;

    typedef struct packed {
        logic     load;
        logic     store;
        logic     mem;
        logic     preload;
        logic     canExc;
        memSize_e memSize;
    } memFlags_t;

    typedef struct packed {
        logic              hasConst;
        logic [ConstW-1:0] constVal;
        logic [2:0]        len;
    } constInfo_t;

    typedef struct packed {
        unitFlags_t unit;
        memFlags_t  memf;
        constInfo_t cinfo;
    } decodeBus_t;

    // Load and store groups are needed by several classifiers
    function automatic logic isLoadOp(opcode_e op);
        return (op == OpLb) || (op == OpLbu) || (op == OpLx);
    endfunction

    function automatic logic isStoreOp(opcode_e op);
        return (op == OpSb) || (op == OpSx);
    endfunction

endpackage

`default_nettype wire

/* hw/idecTop.sv */
// One instruction per cycle, one cycle latency, no back-pressure; config writes act one edge later
`timescale 1ns/1ps
`default_nettype none

module idecTop import idecPkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_i,
    input  wire logic [InstrW-1:0] instr_i,
    input  wire logic [RegW-1:0]   rt_i,
    input  wire logic [TagW-1:0]   id_i,
    input  wire logic              idv_i,
    input  wire logic              cfgWe_i,
    input  wire cfg_t              cfgData_i,
    output decodeBus_t             bus_o,
    output logic [TagW-1:0]        id_o,
    output logic                   idv_o
);

    cfg_t       cfg;
    unitFlags_t unit;
    memFlags_t  memf;
    constInfo_t cinfo;

    idecCfgRegs idecCfgRegs_i (
        .clk       (clk),
        .rst_i     (rst_i),
        .cfgWe_i   (cfgWe_i),
        .cfgData_i (cfgData_i),
        .cfg_o     (cfg)
    );

    // Classifiers
    idecUnitClass idecUnitClass_i (
        .instr_i (instr_i),
        .rt_i    (rt_i),
        .unit_o  (unit)
    );

    idecMemExcClass idecMemExcClass_i (
        .instr_i   (instr_i),
        .rt_i      (rt_i),
        .debugOn_i (cfg.debugOn),
        .memf_o    (memf)
    );

    idecConstExtract idecConstExtract_i (
        .instr_i  (instr_i),
        .predOn_i (cfg.predOn),
        .cinfo_o  (cinfo)
    );

    idecOutStage idecOutStage_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .unit_i  (unit),
        .memf_i  (memf),
        .cinfo_i (cinfo),
        .id_i    (id_i),
        .idv_i   (idv_i),
        .bus_o   (bus_o),
        .id_o    (id_o),
        .idv_o   (idv_o)
    );

endmodule

`default_nettype wire

/* hw/idecUnitClass.sv */
// Combinational; rfw is suppressed for target register zero, opcodes outside the map act as ALU
`timescale 1ns/1ps
`default_nettype none

module idecUnitClass import idecPkg::*; (
    input  wire logic [InstrW-1:0] instr_i,
    input  wire logic [RegW-1:0]   rt_i,
    output unitFlags_t             unit_o
);

    opcode_e op;
    funct_e  fn;
    logic    rfwRaw;

    assign op = opcode_e'(instr_i[OpHi:OpLo]);
    assign fn = funct_e'(instr_i[FnHi:FnLo]);

    always_comb begin
        unit_o     = '0;
        unit_o.alu = 1'b1;
        rfwRaw     = 1'b0;
        case (op)
            // ====================
            // Flow control
            // ====================
            OpBrk: begin
                unit_o.alu       = 1'b0;
                unit_o.flowCtrl  = 1'b1;
                unit_o.updateBtb = 1'b1;
            end
            OpBcc: begin
                unit_o.alu      = 1'b0;
                unit_o.flowCtrl = 1'b1;
                unit_o.branch   = 1'b1;
            end
            OpJmp: begin
                unit_o.alu      = 1'b0;
                unit_o.flowCtrl = 1'b1;
                unit_o.jmp      = 1'b1;
            end
            // Calculated or unknown targets refresh the BTB
            OpJal, OpRet: begin
                unit_o.alu       = 1'b0;
                unit_o.flowCtrl  = 1'b1;
                unit_o.updateBtb = 1'b1;
                rfwRaw           = 1'b1;
            end
            OpCall: begin
                unit_o.alu      = 1'b0;
                unit_o.flowCtrl = 1'b1;
                rfwRaw          = 1'b1;
            end
            // ====================
            // Compute
            // ====================
            OpFloat: begin
                unit_o.alu = 1'b0;
                unit_o.fpu = 1'b1;
            end
            OpR2: begin
                case (fn)
                    FnRti: begin
                        unit_o.alu       = 1'b0;
                        unit_o.flowCtrl  = 1'b1;
                        unit_o.updateBtb = 1'b1;
                    end
                    // Compare writes the predicate file only
                    FnCmp: unit_o.prfw = 1'b1;
                    FnMul, FnDiv, FnMin, FnMax: begin
                        unit_o.alu0Only = 1'b1;
                        rfwRaw          = 1'b1;
                    end
                    default: rfwRaw = 1'b1;
                endcase
            end
            OpCmpi: unit_o.prfw = 1'b1;
            OpMuli, OpDivi: begin
                unit_o.alu0Only = 1'b1;
                rfwRaw          = 1'b1;
            end
            OpAddi, OpAndi, OpOri: rfwRaw = 1'b1;
            default: rfwRaw = isLoadOp(op);
        endcase
        // Writes to r0 are discarded
        unit_o.rfw = rfwRaw && (rt_i != '0);
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ps --top-module idecTb \
    -f build.f --Mdir "$OBJ" -o idecSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/idecSim" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi

exit 0

/* verif/idecClkGen.sv */
// Free-running 40 ns clock; reset is high from time zero and released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module idecClkGen (
    output logic clk,
    output logic rst_o
);

    localparam int HalfPeriod  = 20;
    localparam int ResetCycles = 10;

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk;
    end

    // Held over ten capture edges, dropped away from the rising edge
    initial begin
        rst_o = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* verif/idecTb.sv */
// Directed decoder tests; inputs change on falling edges and outputs are checked one edge later
`timescale 1ns/1ps
`default_nettype none

module idecTb import idecPkg::*; ();

    localparam int ClkPeriod    = 40;
    // Reset plus every decode and config write of all tests
    localparam int TestCycles   = 330;
    localparam int MarginCycles = 100;
    localparam int RandomCount  = 200;

    logic              clk;
    logic              rst;
    logic [InstrW-1:0] instr;
    logic [RegW-1:0]   rt;
    logic [TagW-1:0]   id;
    logic              idv;
    logic              cfgWe;
    cfg_t              cfgData;
    decodeBus_t        bus;
    logic [TagW-1:0]   idOut;
    logic              idvOut;

    // Mode bits the DUT should hold
    cfg_t              cfgModel;
    logic [TagW-1:0]   nextTag;
    int                seed;

    // Outputs expected until the next rising edge
    decodeBus_t        prevBus;
    logic [TagW-1:0]   prevId;
    logic              prevIdv;

    idecClkGen idecClkGen_i (
        .clk   (clk),
        .rst_o (rst)
    );

    idecTop idecTop_i (
        .clk       (clk),
        .rst_i     (rst),
        .instr_i   (instr),
        .rt_i      (rt),
        .id_i      (id),
        .idv_i     (idv),
        .cfgWe_i   (cfgWe),
        .cfgData_i (cfgData),
        .bus_o     (bus),
        .id_o      (idOut),
        .idv_o     (idvOut)
    );

    // ====================
    // Reference model
    // ====================
    function automatic decodeBus_t expectedDecode(logic [InstrW-1:0] ins,
                                                  logic [RegW-1:0] rtSel, cfg_t cfg);
        decodeBus_t  e;
        opcode_e     op;
        funct_e      fn;
        logic        isR2;
        logic        isRti;
        logic        isLoad;
        logic        isStore;
        logic        writes;
        logic [3:0]  szField;
        logic [10:0] loopDisp;
        logic [29:0] longImm;
        logic [13:0] shortImm;
        e        = '0;
        op       = opcode_e'(ins[5:0]);
        fn       = funct_e'(ins[31:26]);
        isR2     = (op == OpR2);
        isRti    = isR2 && (fn == FnRti);
        isLoad   = op inside {OpLb, OpLbu, OpLx};
        isStore  = op inside {OpSb, OpSx};

        // Unit classes
        e.unit.flowCtrl  = (op inside {OpBrk, OpBcc, OpJal, OpJmp, OpCall, OpRet}) || isRti;
        e.unit.alu       = !(e.unit.flowCtrl || (op == OpFloat));
        e.unit.alu0Only  = (isR2 && (fn inside {FnMul, FnDiv, FnMin, FnMax}))
                           || (op inside {OpMuli, OpDivi});
        e.unit.fpu       = (op == OpFloat);
        e.unit.branch    = (op == OpBcc);
        e.unit.jmp       = (op == OpJmp);
        e.unit.updateBtb = (op inside {OpJal, OpRet, OpBrk}) || isRti;
        e.unit.prfw      = (isR2 && (fn == FnCmp)) || (op == OpCmpi);
        writes = (isR2 && !(fn inside {FnCmp, FnRti}))
                 || (op inside {OpAddi, OpAndi, OpOri, OpMuli, OpDivi, OpJal, OpCall, OpRet})
                 || isLoad;
        e.unit.rfw = writes && (rtSel != 5'd0);

        // Memory class and size
        e.memf.load    = isLoad;
        e.memf.store   = isStore;
        e.memf.mem     = isLoad || isStore || (op == OpRet);
        e.memf.preload = isLoad && (rtSel == 5'd0);
        szField = (op == OpLx) ? ins[21:18] : ins[16:13];
        if (op inside {OpLb, OpLbu, OpSb}) begin
            e.memf.memSize = SzByte;
        end else if (op inside {OpLx, OpSx}) begin
            casez (szField)
                4'b1000: e.memf.memSize = SzHexi;
                4'b?1??: e.memf.memSize = SzOcta;
                4'b?01?: e.memf.memSize = SzTetra;
                4'b?001: e.memf.memSize = SzWyde;
                default: e.memf.memSize = SzOcta;
            endcase
        end else begin
            e.memf.memSize = SzOcta;
        end

        // Exception capability
        loopDisp = ins[7] ? LoopDispBack : LoopDispFwd;
        if (cfg.debugOn) begin
            e.memf.canExc = 1'b1;
        end else if ((op inside {OpFloat, OpMuli, OpDivi})
                     || (isR2 && (fn inside {FnMul, FnDiv, FnRti}))) begin
            e.memf.canExc = 1'b1;
        end else if (op == OpBcc) begin
            e.memf.canExc = (ins[31:21] == loopDisp);
        end else begin
            e.memf.canExc = e.memf.mem;
        end

        // Constant and length
        e.cinfo.hasConst = (op inside {OpAddi, OpAndi, OpOri, OpMuli, OpDivi, OpJal, OpCall,
                                       OpRet}) || isLoad || isStore;
        longImm  = isStore ? {ins[47:23], ins[17:13]} : ins[47:18];
        shortImm = isStore ? {ins[31:23], ins[17:13]} : ins[31:18];
        if (ins[6]) begin
            e.cinfo.constVal = 64'($signed(longImm));
        end else begin
            e.cinfo.constVal = 64'($signed(shortImm));
        end
        case (ins[7:6])
            2'b00:   e.cinfo.len = 3'd4;
            2'b01:   e.cinfo.len = 3'd6;
            default: e.cinfo.len = 3'd2;
        endcase
        e.cinfo.len[0] = e.cinfo.len[0] | cfg.predOn;
        return e;
    endfunction

    // ====================
    // Helpers
    // ====================
    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkValue(input string testName, input logic [127:0] expected,
                              input logic [127:0] actual);
        if (expected !== actual) begin
            failRun($sformatf("mismatch in %s: expected %0h, actual %0h",
                              testName, expected, actual));
        end
    endtask

    function automatic logic [InstrW-1:0] randomInstr();
        logic [63:0] rnd;
        rnd = {$random(seed), $random(seed)};
        return rnd[InstrW-1:0];
    endfunction

    function automatic logic [InstrW-1:0] setOpcode(logic [InstrW-1:0] base, opcode_e op);
        logic [InstrW-1:0] r;
        r = base;
        r[OpHi:OpLo] = op;
        return r;
    endfunction

    function automatic cfg_t makeCfg(logic dbg, logic pred);
        cfg_t c;
        c.debugOn = dbg;
        c.predOn  = pred;
        return c;
    endfunction

    // Called just after a falling edge; returns one falling edge later
    task automatic decodeAndCheck(input string name, input logic [InstrW-1:0] ins,
                                  input logic [RegW-1:0] rtSel, input logic valid);
        decodeBus_t      expBus;
        logic [TagW-1:0] tag;
        tag     = nextTag;
        nextTag = nextTag + 1'b1;
        expBus  = expectedDecode(ins, rtSel, cfgModel);
        instr   = ins;
        rt      = rtSel;
        id      = tag;
        idv     = valid;
        // Registered outputs keep the previous word until the edge
        #(ClkPeriod / 4);
        checkValue({name, " bus held"}, 128'(prevBus), 128'(bus));
        checkValue({name, " id held"}, 128'(prevId), 128'(idOut));
        checkValue({name, " idv held"}, 128'(prevIdv), 128'(idvOut));
        @(posedge clk);
        @(negedge clk);
        checkValue({name, " bus"}, 128'(expBus), 128'(bus));
        checkValue({name, " id"}, 128'(tag), 128'(idOut));
        checkValue({name, " idv"}, 128'(valid), 128'(idvOut));
        prevBus = expBus;
        prevId  = tag;
        prevIdv = valid;
    endtask

    task automatic writeConfig(input cfg_t value);
        idv     = 1'b0;
        cfgWe   = 1'b1;
        cfgData = value;
        @(posedge clk);
        @(negedge clk);
        cfgWe    = 1'b0;
        // The write edge also captures an idle decode under the old mode bits
        prevBus  = expectedDecode(instr, rt, cfgModel);
        prevId   = id;
        prevIdv  = 1'b0;
        cfgModel = value;
    endtask

    task automatic checkBranch(input string name, input logic dir, input logic [10:0] disp,
                               input logic expExc);
        logic [InstrW-1:0] ins;
        ins                = '0;
        ins[OpHi:OpLo]     = OpBcc;
        ins[DirBit]        = dir;
        ins[DispHi:DispLo] = disp;
        decodeAndCheck(name, ins, 5'd0, 1'b1);
        checkValue({name, " canExc"}, 128'(expExc), 128'(bus.memf.canExc));
    endtask

    // ====================
    // Tests
    // ====================
    task automatic testReset();
        checkValue("reset idv", 128'd0, 128'(idvOut));
        checkValue("reset id", 128'd0, 128'(idOut));
        checkValue("reset bus", 128'd0, 128'(bus));
    endtask

    task automatic testUnitClasses();
        opcode_e           op;
        funct_e            fn;
        logic [InstrW-1:0] ins;
        op = op.first();
        for (int i = 0; i < op.num(); i++) begin
            ins = setOpcode(randomInstr(), op);
            decodeAndCheck($sformatf("unit %s rt3", op.name()), ins, 5'd3, 1'b1);
            decodeAndCheck($sformatf("unit %s rt0", op.name()), ins, 5'd0, 1'b1);
            op = op.next();
        end
        fn = fn.first();
        for (int i = 0; i < fn.num(); i++) begin
            ins = setOpcode(randomInstr(), OpR2);
            ins[FnHi:FnLo] = fn;
            decodeAndCheck($sformatf("r2 %s rt9", fn.name()), ins, 5'd9, 1'b1);
            decodeAndCheck($sformatf("r2 %s rt0", fn.name()), ins, 5'd0, 1'b1);
            fn = fn.next();
        end
        // Target r0 drops the register write
        decodeAndCheck("addi rt0", setOpcode(randomInstr(), OpAddi), 5'd0, 1'b1);
        checkValue("addi rt0 rfw", 128'd0, 128'(bus.unit.rfw));
    endtask

    task automatic testMemory();
        logic [InstrW-1:0] ins;
        ins = setOpcode(randomInstr(), OpLb);
        decodeAndCheck("lb rt0", ins, 5'd0, 1'b1);
        checkValue("lb rt0 preload", 128'd1, 128'(bus.memf.preload));
        decodeAndCheck("lb rt7", ins, 5'd7, 1'b1);
        checkValue("lb rt7 preload", 128'd0, 128'(bus.memf.preload));
        decodeAndCheck("lbu", setOpcode(randomInstr(), OpLbu), 5'd4, 1'b1);
        decodeAndCheck("sb", setOpcode(randomInstr(), OpSb), 5'd4, 1'b1);
        for (int sz = 0; sz < 16; sz++) begin
            ins = setOpcode(randomInstr(), OpLx);
            ins[LxSzHi:LxSzLo] = 4'(sz);
            decodeAndCheck($sformatf("lx size %b", 4'(sz)), ins, 5'd6, 1'b1);
            if (sz == 8) begin
                checkValue("lx size hexi", 128'(SzHexi), 128'(bus.memf.memSize));
            end
            ins = setOpcode(randomInstr(), OpSx);
            ins[SxSzHi:SxSzLo] = 4'(sz);
            decodeAndCheck($sformatf("sx size %b", 4'(sz)), ins, 5'd0, 1'b1);
        end
    endtask

    task automatic testExceptions();
        logic [InstrW-1:0] ins;
        checkBranch("bcc fwd loop", 1'b0, LoopDispFwd, 1'b1);
        checkBranch("bcc back loop", 1'b1, LoopDispBack, 1'b1);
        checkBranch("bcc fwd wrong", 1'b0, LoopDispBack, 1'b0);
        checkBranch("bcc back wrong", 1'b1, LoopDispFwd, 1'b0);
        checkBranch("bcc plain", 1'b0, 11'h012, 1'b0);
        ins = setOpcode('0, OpR2);
        ins[FnHi:FnLo] = FnAdd;
        decodeAndCheck("add normal", ins, 5'd2, 1'b1);
        checkValue("add normal canExc", 128'd0, 128'(bus.memf.canExc));
        writeConfig(makeCfg(1'b1, 1'b0));
        decodeAndCheck("add debug", ins, 5'd2, 1'b1);
        checkValue("add debug canExc", 128'd1, 128'(bus.memf.canExc));
        writeConfig(makeCfg(1'b0, 1'b0));
    endtask

    task automatic testConstants();
        opcode_e           constOps [13];
        logic [InstrW-1:0] ins;
        logic [3:0]        pick;
        constOps = '{OpAddi, OpAndi, OpOri, OpMuli, OpDivi, OpLb, OpLbu, OpLx, OpSb, OpSx,
                     OpJal, OpCall, OpRet};
        for (int n = 0; n < RandomCount; n++) begin
            if (n == 67) begin
                writeConfig(makeCfg(1'b0, 1'b1));
            end
            if (n == 134) begin
                writeConfig(makeCfg(1'b0, 1'b0));
            end
            // Bit 6 is random so long and short forms both appear
            ins = randomInstr();
            if (n % 4 != 3) begin
                pick = 4'({$random(seed)} % 13);
                ins[OpHi:OpLo] = constOps[pick];
            end
            decodeAndCheck($sformatf("const random %0d", n), ins, RegW'($random(seed)), 1'b1);
        end
    endtask

    task automatic testBackToBack();
        decodeAndCheck("b2b first", setOpcode(randomInstr(), OpAddi), 5'd1, 1'b1);
        decodeAndCheck("b2b second", setOpcode(randomInstr(), OpSx), 5'd2, 1'b1);
        decodeAndCheck("b2b idle", randomInstr(), 5'd3, 1'b0);
        decodeAndCheck("b2b third", setOpcode(randomInstr(), OpJal), 5'd4, 1'b1);
    endtask

    // ====================
    // Sequence
    // ====================
    initial begin
        instr    = '0;
        rt       = '0;
        id       = '0;
        idv      = 1'b0;
        cfgWe    = 1'b0;
        cfgData  = '0;
        cfgModel = '0;
        nextTag  = '0;
        prevBus  = '0;
        prevId   = '0;
        prevIdv  = 1'b0;
        seed     = 69;
        @(negedge rst);
        testReset();
        testUnitClasses();
        testMemory();
        testExceptions();
        testConstants();
        testBackToBack();
        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog
    initial begin
        #(ClkPeriod * (TestCycles + MarginCycles));
        failRun("timeout: the tests did not finish within the cycle budget");
    end

endmodule

`default_nettype wire
